// File: hw/isa_pkg.sv
// RV32I integer subset only; no division, CSR or JALR target masking encodings
package isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;                      // Shift amount is b[4:0]
    localparam logic [REG_ADDR_W-1:0] ZERO_REG = '0;    // x0 is hardwired

    // Iterations of the shift-add multiplier
    localparam int MUL_CYCLES = 32;
    localparam int MUL_CNT_W  = $clog2(MUL_CYCLES + 1);

    // Exact operation the ALU performs
    typedef enum logic [4:0] {
        ADD  = 5'd0,
        SUB  = 5'd1,
        AND  = 5'd2,
        OR   = 5'd3,
        XOR  = 5'd4,
        SLL  = 5'd5,
        SRL  = 5'd6,
        SRA  = 5'd7,
        SLT  = 5'd8,
        SLTU = 5'd9,
        MUL  = 5'd10
    } alu_ctrl_e;

    // Operand class picks the ALU inputs
    typedef enum logic [2:0] {
        LOAD_STORE = 3'b000,
        BRANCH     = 3'b001,
        REG_IMM    = 3'b010,
        JUMP       = 3'b011,
        LUI        = 3'b100,
        AUIPC      = 3'b101
    } opnd_class_e;

    typedef enum logic [2:0] {BEQ = 3'b000, BNE = 3'b001, BLT = 3'b100,
                              BGE = 3'b101, BLTU = 3'b110, BGEU = 3'b111} branch_e;

endpackage

// File: hw/pipe_pkg.sv
// Stage-to-stage records; the issue side must start with ISSUE_CREDITS and never exceed it
package pipe_pkg;

    // Operation as it leaves decode
    typedef struct packed {
        logic [isa_pkg::XLEN-1:0]       rs1_value;
        logic [isa_pkg::XLEN-1:0]       rs2_value;
        logic [isa_pkg::XLEN-1:0]       imm;
        logic [isa_pkg::XLEN-1:0]       pc;
        logic [isa_pkg::REG_ADDR_W-1:0] rs1_addr;
        logic [isa_pkg::REG_ADDR_W-1:0] rs2_addr;
        logic [isa_pkg::REG_ADDR_W-1:0] rd;
        logic                           use_imm;    // REG_IMM takes imm instead of rs2
        logic                           reg_write;
        logic                           is_branch;
        isa_pkg::alu_ctrl_e             alu_ctrl;
        isa_pkg::opnd_class_e           opnd_class;
        isa_pkg::branch_e               branch_kind;
    } ex_op_t;

    typedef struct packed {
        logic                           valid;
        logic [isa_pkg::REG_ADDR_W-1:0] rd;
        logic [isa_pkg::XLEN-1:0]       data;
    } bypass_t;

    // Result handed to the memory stage
    typedef struct packed {
        logic [isa_pkg::XLEN-1:0]       result;
        logic [isa_pkg::REG_ADDR_W-1:0] rd;
        logic                           reg_write;
        logic                           branch_taken;
        logic [isa_pkg::XLEN-1:0]       branch_target;
    } ex_res_t;

    localparam int ISSUE_CREDITS   = 1;     // Same as input slot depth
    localparam int RES_CREDITS_MAX = 4;
    localparam int RES_CNT_W       = $clog2(RES_CREDITS_MAX + 1);

endpackage

// File: hw/operand_forward.sv
// Purely combinational; ex_bypass has priority over wb_bypass and x0 is never forwarded
`timescale 1ns/1ps

module operand_forward (
    input  logic [isa_pkg::REG_ADDR_W-1:0] rs1_addr,
    input  logic [isa_pkg::REG_ADDR_W-1:0] rs2_addr,
    input  logic [isa_pkg::XLEN-1:0]       rs1_value,
    input  logic [isa_pkg::XLEN-1:0]       rs2_value,
    input  pipe_pkg::bypass_t              ex_bypass,
    input  pipe_pkg::bypass_t              wb_bypass,
    output logic [isa_pkg::XLEN-1:0]       rs1_fwd,
    output logic [isa_pkg::XLEN-1:0]       rs2_fwd
);
    import isa_pkg::*;
    import pipe_pkg::*;

    // Youngest matching producer wins, register file value otherwise
    function automatic logic [XLEN-1:0] pick_source(
        input logic [REG_ADDR_W-1:0] addr,
        input logic [XLEN-1:0]       reg_value,
        input bypass_t               ex_byp,
        input bypass_t               wb_byp
    );
        logic [XLEN-1:0] value;
        value = reg_value;
        if (addr != ZERO_REG)
        begin
            if (ex_byp.valid && ex_byp.rd == addr)
                value = ex_byp.data;
            else if (wb_byp.valid && wb_byp.rd == addr)
                value = wb_byp.data;
        end
        return value;
    endfunction

    assign rs1_fwd = pick_source(rs1_addr, rs1_value, ex_bypass, wb_bypass);
    assign rs2_fwd = pick_source(rs2_addr, rs2_value, ex_bypass, wb_bypass);

endmodule

// File: hw/alu.sv
// MUL is iterative and keeps busy high for MUL_CYCLES cycles; other operations are combinational
`timescale 1ns/1ps

module alu (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  isa_pkg::alu_ctrl_e       ctrl,
    input  logic [isa_pkg::XLEN-1:0] a,
    input  logic [isa_pkg::XLEN-1:0] b,
    output logic [isa_pkg::XLEN-1:0] result,
    output logic                     zero,
    output logic                     busy
);
    import isa_pkg::*;

    logic                 mul_start;
    logic [XLEN-1:0]      mcand;        // Shifted left each step
    logic [XLEN-1:0]      mplier;       // Shifted right each step
    logic [XLEN-1:0]      product;      // Low word of the partial sum
    logic [MUL_CNT_W-1:0] steps_left;
    logic [SHAMT_W-1:0]   shamt;

    assign mul_start = start && (ctrl == MUL);
    assign shamt     = b[SHAMT_W-1:0];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            busy       <= 1'b0;
            steps_left <= '0;
        end
        else if (mul_start)
        begin
            busy       <= 1'b1;
            steps_left <= MUL_CNT_W'(MUL_CYCLES);
        end
        else if (busy)
        begin
            steps_left <= steps_left - 1'b1;
            if (steps_left == MUL_CNT_W'(1))
                busy <= 1'b0;                   // Last add lands this edge
        end
    end

    // Shift-add datapath
    always_ff @(posedge clk)
    begin
        if (mul_start)
        begin
            mcand   <= a;
            mplier  <= b;
            product <= '0;
        end
        else if (busy)
        begin
            if (mplier[0])
                product <= product + mcand;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    always_comb
    begin
        case (ctrl)
            ADD:     result = a + b;
            SUB:     result = a - b;
            AND:     result = a & b;
            OR:      result = a | b;
            XOR:     result = a ^ b;
            SLL:     result = a << shamt;
            SRL:     result = a >> shamt;
            SRA:     result = $signed(a) >>> shamt;
            SLT:     result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            SLTU:    result = {{(XLEN-1){1'b0}}, a < b};
            MUL:     result = product;          // Valid once busy drops
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);   // Equality test after SUB

endmodule

// File: hw/execute_stage.sv
// One-deep input slot; operands are forwarded only at accept and a result needs a held credit
`timescale 1ns/1ps

module execute_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     issue_valid,
    input  pipe_pkg::ex_op_t         issue_op,
    input  logic [isa_pkg::XLEN-1:0] rs1_fwd,
    input  logic [isa_pkg::XLEN-1:0] rs2_fwd,
    input  logic                     res_credit,
    output logic                     issue_credit,
    output pipe_pkg::ex_op_t         fwd_op,
    output pipe_pkg::bypass_t        ex_bypass,
    output logic                     res_valid,
    output pipe_pkg::ex_res_t        res
);
    import isa_pkg::*;
    import pipe_pkg::*;

    ex_op_t               slot;
    logic                 slot_valid;
    logic                 slot_was_valid;       // Slot state one cycle back
    logic                 accept;
    logic                 fire;                 // Result register written this edge
    logic [XLEN-1:0]      alu_a;
    logic [XLEN-1:0]      alu_b;
    logic [XLEN-1:0]      alu_result;
    logic                 alu_zero;
    logic                 alu_busy;
    logic                 alu_start;
    logic                 alu_done;
    logic                 mul_started;
    logic                 cond_met;
    logic [XLEN-1:0]      branch_target;
    logic [RES_CNT_W-1:0] res_credits;
    logic                 byp_valid;

    assign fwd_op = issue_op;                   // Forwarding looks at the arriving operation
    assign accept = issue_valid && !slot_valid;

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            slot           <= issue_op;
            slot.rs1_value <= rs1_fwd;          // Frozen from here on
            slot.rs2_value <= rs2_fwd;
        end
    end

    always_comb
    begin
        case (slot.opnd_class)
            LOAD_STORE:
            begin
                alu_a = slot.rs1_value;
                alu_b = slot.imm;
            end
            BRANCH:
            begin
                alu_a = slot.rs1_value;
                alu_b = slot.rs2_value;
            end
            REG_IMM:
            begin
                alu_a = slot.rs1_value;
                alu_b = slot.use_imm ? slot.imm : slot.rs2_value;
            end
            LUI:
            begin
                alu_a = slot.imm;
                alu_b = '0;
            end
            default:    // JUMP and AUIPC
            begin
                alu_a = slot.pc;
                alu_b = slot.imm;
            end
        endcase
    end

    assign alu_start = slot_valid && (slot.alu_ctrl == MUL) && !mul_started;
    assign alu_done  = (slot.alu_ctrl != MUL) || (mul_started && !alu_busy);
    assign fire      = slot_valid && alu_done && (res_credits != '0);

    alu u_alu (
        .clk    (clk),
        .rst    (rst),
        .start  (alu_start),
        .ctrl   (slot.alu_ctrl),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .zero   (alu_zero),
        .busy   (alu_busy)
    );

    // Decode sets SUB, SLT or SLTU to match the branch kind
    always_comb
    begin
        case (slot.branch_kind)
            BEQ:     cond_met = alu_zero;
            BNE:     cond_met = !alu_zero;
            BLT,
            BLTU:    cond_met = alu_result[0];
            BGE,
            BGEU:    cond_met = !alu_result[0];
            default: cond_met = 1'b0;
        endcase
    end

    assign branch_target = slot.pc + slot.imm;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            slot_valid     <= 1'b0;
            slot_was_valid <= 1'b0;
            mul_started    <= 1'b0;
            res_valid      <= 1'b0;
            byp_valid      <= 1'b0;
            res_credits    <= '0;
        end
        else
        begin
            if (accept)
                slot_valid <= 1'b1;
            else if (fire)
                slot_valid <= 1'b0;
            slot_was_valid <= slot_valid;
            if (fire)
                mul_started <= 1'b0;
            else if (alu_start)
                mul_started <= 1'b1;
            res_valid <= fire;
            if (fire)
                byp_valid <= slot.reg_write && (slot.rd != ZERO_REG);
            case ({res_credit, fire})
                2'b10: if (res_credits != RES_CNT_W'(RES_CREDITS_MAX))
                    res_credits <= res_credits + 1'b1;      // Excess grant is dropped
                2'b01: res_credits <= res_credits - 1'b1;
                default: res_credits <= res_credits;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (fire)
        begin
            res.result        <= alu_result;
            res.rd            <= slot.rd;
            res.reg_write     <= slot.reg_write;
            res.branch_taken  <= slot.is_branch && cond_met;
            res.branch_target <= branch_target;
        end
    end

    // Credit returns in the cycle after the slot empties
    assign issue_credit = slot_was_valid && !slot_valid;
    assign ex_bypass    = '{valid: byp_valid, rd: res.rd, data: res.result};

endmodule

// File: hw/ex_top.sv
// Standalone execute stage; wb_bypass stands in for the memory and write-back stages
`timescale 1ns/1ps

module ex_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              issue_valid,
    input  pipe_pkg::ex_op_t  issue_op,
    input  pipe_pkg::bypass_t wb_bypass,
    input  logic              res_credit,
    output logic              issue_credit,
    output logic              res_valid,
    output pipe_pkg::ex_res_t res
);
    import isa_pkg::*;
    import pipe_pkg::*;

    ex_op_t          fwd_op;
    bypass_t         ex_bypass;     // Last result of this stage
    logic [XLEN-1:0] rs1_fwd;
    logic [XLEN-1:0] rs2_fwd;

    operand_forward u_fwd (
        .rs1_addr  (fwd_op.rs1_addr),
        .rs2_addr  (fwd_op.rs2_addr),
        .rs1_value (fwd_op.rs1_value),
        .rs2_value (fwd_op.rs2_value),
        .ex_bypass (ex_bypass),
        .wb_bypass (wb_bypass),
        .rs1_fwd   (rs1_fwd),
        .rs2_fwd   (rs2_fwd)
    );

    execute_stage u_stage (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .rs1_fwd      (rs1_fwd),
        .rs2_fwd      (rs2_fwd),
        .res_credit   (res_credit),
        .issue_credit (issue_credit),
        .fwd_op       (fwd_op),
        .ex_bypass    (ex_bypass),
        .res_valid    (res_valid),
        .res          (res)
    );

endmodule

// File: testbench/ex_sva.sv
// Credit rules on the ex_top ports; the result credit count is rebuilt from the port pulses
`timescale 1ns/1ps

module ex_sva (
    input logic clk,
    input logic rst,
    input logic res_credit,
    input logic res_valid,
    input logic issue_credit
);
    import pipe_pkg::*;

    int held;       // Grants seen minus results seen
    int fails = 0;  // Failed assertions so far

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            held <= 0;
        else
            held <= held + int'(res_credit) - int'(res_valid);
    end

    a_res_needs_credit: assert property (@(posedge clk) disable iff (rst)
        res_valid |-> held > 0)
        else
        begin
            $error("result delivered without a held result credit");
            fails++;
        end

    a_no_credit_overflow: assert property (@(posedge clk) disable iff (rst)
        res_credit |-> held < RES_CREDITS_MAX)
        else
        begin
            $error("result credit granted while the stage is full");
            fails++;
        end

    a_issue_credit_with_result: assert property (@(posedge clk) disable iff (rst)
        issue_credit |-> res_valid)
        else
        begin
            $error("issue credit returned without a result");
            fails++;
        end

endmodule

bind ex_top ex_sva u_sva (
    .clk          (clk),
    .rst          (rst),
    .res_credit   (res_credit),
    .res_valid    (res_valid),
    .issue_credit (issue_credit)
);

// File: testbench/ex_checker.sv
// Results must arrive in table order; every res_valid consumes the next expected entry
`timescale 1ns/1ps

module ex_checker #(
    parameter int N_TESTS = 1
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              issue_valid,
    input  logic              res_credit,
    input  logic              issue_credit,
    input  logic              res_valid,
    input  pipe_pkg::ex_res_t res,
    input  pipe_pkg::ex_res_t exp_tab [N_TESTS],
    output int                checked,
    output int                errors
);
    import pipe_pkg::*;

    int      grants;
    int      credits_back;
    logic    started;       // First operation has been issued
    logic    bad;
    ex_res_t e;

    initial
    begin
        checked = 0;
        errors = 0;
        grants = 0;
        credits_back = 0;
        started = 1'b0;
    end

    always @(posedge clk)
    begin
        if (!rst)
        begin
            if (!started && (res_valid || issue_credit))
            begin
                $display("Output handshake active before any operation was issued");
                errors++;
            end
            if (issue_valid)
                started = 1'b1;
            if (res_valid)
            begin
                if (checked >= N_TESTS)
                begin
                    $display("Unexpected extra result at %0d ns", $time);
                    errors++;
                end
                else
                begin
                    e = exp_tab[checked];
                    bad = 1'b0;
                    if (res.result !== e.result)
                    begin
                        $display("[ERROR] %0d ns: test %0d result %h, expected %h",
                                 $time, checked, res.result, e.result);
                        bad = 1'b1;
                    end
                    if (res.rd !== e.rd || res.reg_write !== e.reg_write)
                    begin
                        $display("[ERROR] %0d ns: test %0d rd/reg_write %0d/%b, expected %0d/%b",
                                 $time, checked, res.rd, res.reg_write, e.rd, e.reg_write);
                        bad = 1'b1;
                    end
                    if (res.branch_taken !== e.branch_taken)
                    begin
                        $display("[ERROR] %0d ns: test %0d branch_taken %b, expected %b",
                                 $time, checked, res.branch_taken, e.branch_taken);
                        bad = 1'b1;
                    end
                    if (res.branch_target !== e.branch_target)
                    begin
                        $display("[ERROR] %0d ns: test %0d branch_target %h, expected %h",
                                 $time, checked, res.branch_target, e.branch_target);
                        bad = 1'b1;
                    end
                    if (bad)
                        errors++;
                    else
                        $display("test %0d passed", checked);
                end
                checked++;
                if (checked > grants)
                begin
                    $display("More results delivered than result credits granted");
                    errors++;
                end
            end
            if (issue_credit)
                credits_back++;
            if (credits_back > checked)
            begin
                $display("More issue credits returned than results delivered");
                errors++;
            end
            if (res_credit)
                grants++;   // Counted after the check, a grant is usable from the next edge
        end
    end

endmodule

// File: testbench/tb_ex.sv
// Issues one operation per issue credit; result credits are granted at random with a fixed seed
`timescale 1ns/1ps

module tb_ex;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int              N_TESTS = 26;
    localparam int              PERIOD  = 40;
    localparam logic [XLEN-1:0] PC      = 32'h100;
    localparam bypass_t         NO_WB   = '0;

    logic    clk;
    logic    rst;
    logic    issue_valid;
    ex_op_t  issue_op;
    bypass_t wb_bypass;
    logic    res_credit;
    logic    issue_credit;
    logic    res_valid;
    ex_res_t res;

    ex_op_t  ops [N_TESTS];
    bypass_t wbs [N_TESTS];
    ex_res_t exp_tab [N_TESTS];
    int      n_built;
    int      checked;
    int      errors;
    int      granted;
    int      consumed;

    ex_top UUT (.clk(clk), .rst(rst), .issue_valid(issue_valid), .issue_op(issue_op),
                .wb_bypass(wb_bypass), .res_credit(res_credit), .issue_credit(issue_credit),
                .res_valid(res_valid), .res(res));

    ex_checker #(.N_TESTS(N_TESTS)) u_checker (
        .clk(clk), .rst(rst), .issue_valid(issue_valid), .res_credit(res_credit),
        .issue_credit(issue_credit), .res_valid(res_valid), .res(res),
        .exp_tab(exp_tab), .checked(checked), .errors(errors));

    always #(PERIOD / 2) clk = ~clk;

    function automatic ex_op_t make_op(opnd_class_e cls, alu_ctrl_e ctrl, branch_e bk,
            logic [4:0] a1, logic [31:0] v1, logic [4:0] a2, logic [31:0] v2,
            logic [31:0] imm, logic [4:0] rd, logic use_imm, logic regw);
        ex_op_t op;
        op = '{rs1_value: v1, rs2_value: v2, imm: imm, pc: PC, rs1_addr: a1, rs2_addr: a2,
               rd: rd, use_imm: use_imm, reg_write: regw, is_branch: cls == BRANCH,
               alu_ctrl: ctrl, opnd_class: cls, branch_kind: bk};
        return op;
    endfunction

    function automatic bypass_t make_wb(logic [4:0] rd, logic [31:0] data);
        return '{valid: 1'b1, rd: rd, data: data};
    endfunction

    // Target is always pc plus imm; rd and reg_write pass straight through
    task automatic add_test(ex_op_t op, bypass_t wb, logic [31:0] result, logic taken);
        ops[n_built] = op;
        wbs[n_built] = wb;
        exp_tab[n_built] = '{result: result, rd: op.rd, reg_write: op.reg_write,
                             branch_taken: taken, branch_target: PC + op.imm};
        n_built++;
    endtask

    task automatic build_table();
        n_built = 0;
        add_test(make_op(REG_IMM, ADD, BEQ, 1, 10, 2, 0, 5, 3, 1, 1), NO_WB, 15, 0);
        add_test(make_op(REG_IMM, SUB, BEQ, 4, 100, 5, 30, 0, 6, 0, 1), NO_WB, 70, 0);
        add_test(make_op(REG_IMM, ADD, BEQ, 6, 0, 7, 1, 0, 8, 0, 1), NO_WB, 71, 0);   // ex forward
        add_test(make_op(REG_IMM, XOR, BEQ, 9, 0, 10, 'h0ff0, 0, 11, 0, 1),
                 make_wb(9, 'hff00), 'hf0f0, 0);                                  // wb forward
        add_test(make_op(REG_IMM, OR, BEQ, 11, 0, 2, 0, 'h000f, 12, 1, 1),
                 make_wb(11, 'h1234), 'hf0ff, 0);                                 // ex beats wb
        add_test(make_op(REG_IMM, ADD, BEQ, 1, 7, 2, 0, 1, 0, 1, 1), NO_WB, 8, 0);
        add_test(make_op(REG_IMM, ADD, BEQ, 0, 0, 0, 0, 0, 13, 0, 1),
                 make_wb(0, 'hdead), 0, 0);                                       // x0 stays zero
        add_test(make_op(REG_IMM, AND, BEQ, 1, 'hff0f, 2, 0, 'h0ff0, 14, 1, 1), NO_WB, 'h0f00, 0);
        add_test(make_op(REG_IMM, SLL, BEQ, 1, 1, 2, 0, 4, 15, 1, 1), NO_WB, 'h10, 0);
        add_test(make_op(REG_IMM, SRL, BEQ, 1, 'h80000000, 2, 0, 31, 16, 1, 1), NO_WB, 1, 0);
        add_test(make_op(REG_IMM, SRA, BEQ, 1, 'h80000000, 2, 0, 4, 17, 1, 1),
                 NO_WB, 'hf8000000, 0);
        add_test(make_op(REG_IMM, SLT, BEQ, 1, 'hffffffff, 2, 1, 0, 18, 0, 1), NO_WB, 1, 0);
        add_test(make_op(REG_IMM, SLTU, BEQ, 1, 'hffffffff, 2, 1, 0, 19, 0, 1), NO_WB, 0, 0);
        add_test(make_op(LOAD_STORE, ADD, BEQ, 1, 'h1000, 2, 0, 'h20, 20, 0, 1), NO_WB, 'h1020, 0);
        add_test(make_op(LUI, ADD, BEQ, 1, 5, 2, 0, 'h12345000, 21, 0, 1), NO_WB, 'h12345000, 0);
        add_test(make_op(AUIPC, ADD, BEQ, 1, 5, 2, 0, 'h2000, 22, 0, 1), NO_WB, 'h2100, 0);
        add_test(make_op(JUMP, ADD, BEQ, 1, 5, 2, 0, 'h40, 23, 0, 1), NO_WB, 'h140, 0);
        add_test(make_op(BRANCH, SUB, BEQ, 1, 5, 2, 5, 'h10, 0, 0, 0), NO_WB, 0, 1);
        add_test(make_op(BRANCH, SUB, BNE, 1, 5, 2, 5, 'h10, 0, 0, 0), NO_WB, 0, 0);
        add_test(make_op(BRANCH, SLT, BLT, 1, 'hffffffff, 2, 1, 'hfffffff8, 0, 0, 0), NO_WB, 1, 1);
        add_test(make_op(BRANCH, SLT, BGE, 1, 'hffffffff, 2, 1, 8, 0, 0, 0), NO_WB, 1, 0);
        add_test(make_op(BRANCH, SLTU, BLTU, 1, 'hffffffff, 2, 1, 8, 0, 0, 0), NO_WB, 0, 0);
        add_test(make_op(BRANCH, SLTU, BGEU, 1, 'hffffffff, 2, 1, 8, 0, 0, 0), NO_WB, 0, 1);
        add_test(make_op(REG_IMM, MUL, BEQ, 1, 12345, 2, 6789, 0, 24, 0, 1), NO_WB, 'h04fed79d, 0);
        add_test(make_op(REG_IMM, MUL, BEQ, 1, 'hffffffff, 2, 3, 0, 25, 0, 1),
                 NO_WB, 'hfffffffd, 0);                                           // Low word only
        add_test(make_op(REG_IMM, ADD, BEQ, 25, 0, 2, 5, 0, 26, 0, 1), NO_WB, 2, 0);
    endtask

    // Random grants, never more than the stage can hold
    initial
    begin
        void'($urandom(32'h1e1a));
        forever
        begin
            @(posedge clk);
            if (rst)
                res_credit <= 1'b0;
            else
            begin
                if (res_valid)
                    consumed++;
                if (granted - consumed < RES_CREDITS_MAX && $urandom % 3 == 0)
                begin
                    res_credit <= 1'b1;
                    granted++;
                end
                else
                    res_credit <= 1'b0;
            end
        end
    end

    initial
    begin
        int i;
        int credits;
        clk = 1'b0;
        rst = 1'b1;
        issue_valid = 1'b0;
        issue_op = '0;
        wb_bypass = '0;
        res_credit = 1'b0;
        granted = 0;
        consumed = 0;
        build_table();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        credits = ISSUE_CREDITS;
        i = 0;
        while (i < N_TESTS)
        begin
            @(posedge clk);
            if (issue_credit)
                credits++;
            issue_valid <= 1'b0;
            if (credits > 0)
            begin
                issue_valid <= 1'b1;
                issue_op <= ops[i];
                wb_bypass <= wbs[i];
                credits--;
                i++;
            end
        end
        @(posedge clk);
        issue_valid <= 1'b0;
        wait (checked == N_TESTS);
        repeat (4) @(posedge clk);     // Catch any stray extra result
        $display("Summary: %0d of %0d results checked, %0d errors, %0d assertion failures",
                 checked, N_TESTS, errors, UUT.u_sva.fails);
        if (errors == 0 && UUT.u_sva.fails == 0 && checked == N_TESTS)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    // Watchdog sized for the slowest case, a MUL on every entry
    initial
    begin
        #(N_TESTS * (MUL_CYCLES + 40) * PERIOD);
        $display("Timeout: the DUT stopped delivering results after %0d of %0d", checked, N_TESTS);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: tb.f
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/operand_forward.sv
hw/alu.sv
hw/execute_stage.sv
hw/ex_top.sv
testbench/ex_sva.sv
testbench/ex_checker.sv
testbench/tb_ex.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_ex
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf $(OBJDIR)
